/* test/scope_testdata.txt */
# cmd addr data err: W writes, R reads and compares, all hex, err is the expected pslverr
# F len runs one triggered frame, C n runs n continuous frames, E ends a test
R 008 00000000 0
R 004 00000001 0
R 000 00000000 0
W 004 00000005 0
R 004 00000005 0
E
W 004 00000000 1
R 004 00000005 0
W 004 00000011 1
R 004 00000005 0
W 004 00000010 0
R 004 00000010 0
W 008 00000001 1
W 00C 00000000 1
R 00C 00000000 1
W 100 12345678 1
E
F 3
R 100 01000000 0
R 108 01000002 0
R 10C 020007D0 0
R 12C 04011772 0
R 200 00000000 1
E
F 16
E
W 004 00000002 0
C 3
R 104 01000001 0
R 11C 04011771 0
E

/* sources.f */
design/scope_pkg.sv
design/scope_regs.sv
design/sample_sequencer.sv
design/capture_buffer.sv
design/scope_top.sv
test/scope_chk.sv
test/scope_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module scope_tb -o scope_sim ||
    { echo "build failed"; exit 1; }
out="$(./obj_dir/scope_sim)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

/* test/scope_tb.sv */
// Testbench for scope_top at its default parameters; run from the project root so the test data path resolves
`timescale 1ns/1ns

module scope_tb;

    localparam int N_DEST        = 4;
    localparam int DEST_START    = 1;
    localparam int OUTPUT_BIAS   = 0;
    localparam int BACKOFF_DELAY = 128;
    localparam int BUFFER_DEPTH  = 64;
    // The longest legal frame fills the whole buffer with one beat every SAMPLE_GAP+1 cycles
    localparam int FRAME_CYCLES  = BUFFER_DEPTH * (scope_pkg::SAMPLE_GAP + 1) + BACKOFF_DELAY + 20;

    logic                clock;
    logic                reset;
    scope_pkg::apb_req_t apb_req;
    scope_pkg::apb_rsp_t apb_rsp;
    logic                busy;
    logic [15:0]         frame_count;
    logic [31:0]         lfsr;
    int                  checks;
    int                  errors;
    int                  test_errors;
    int                  tests;
    int                  cur_length = 1;
    int                  watchdog_cycles;
    logic [7:0]          cmd_q[$];
    logic [31:0]         addr_q[$];
    logic [31:0]         data_q[$];
    logic [31:0]         err_q[$];

    scope_top i_dut (.clock, .reset, .apb_req, .apb_rsp, .busy, .frame_count);

    always #5 clock = !clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic bit in_window(input logic [11:0] addr);
        return int'(addr) >= int'(scope_pkg::BUF_BASE) && addr[1:0] == 2'b00 &&
               int'(addr) < int'(scope_pkg::BUF_BASE) + 4 * BUFFER_DEPTH;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            test_errors++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Busy and frame_count straight from the top level, sampled away from the clock edge
    task automatic check_outputs(input logic exp_busy, input logic [15:0] exp_count);
        @(negedge clock);
        check_value("busy output", 32'(busy), 32'(exp_busy));
        check_value("frame_count output", 32'(frame_count), 32'(exp_count));
    endtask

    // Waits zero to three idle cycles with one LFSR step for each of two bits
    task automatic idle_spacing();
        int n;
        lfsr = lfsr_next(lfsr);
        n    = int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        n    = 2 * n + int'(lfsr[0]);
        repeat (n) @(posedge clock);
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int waits;
        idle_spacing();
        @(posedge clock);
        apb_req.paddr   <= addr;
        apb_req.pwrite  <= write;
        apb_req.pwdata  <= wdata;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clock);
        apb_req.penable <= 1'b1;
        waits = 0;
        @(negedge clock);
        while (!apb_rsp.pready && waits < 8) begin
            waits++;
            @(negedge clock);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // Only reads of the buffer window wait, and for exactly one cycle
        check_value($sformatf("wait states at %h", addr), 32'(waits),
                    (!write && in_window(addr)) ? 32'd1 : 32'd0);
        @(posedge clock);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value($sformatf("pslverr on write to %h", addr), 32'(err), 32'(exp_err));
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp_data,
                               input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'd0, rdata, err);
        check_value($sformatf("prdata at %h", addr), rdata, exp_data);
        check_value($sformatf("pslverr on read of %h", addr), 32'(err), 32'(exp_err));
    endtask

    task automatic read_status(output logic busy_bit, output logic [15:0] count);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, scope_pkg::ADDR_STATUS, 32'd0, rdata, err);
        check_value("pslverr on STATUS read", 32'(err), 32'd0);
        busy_bit = rdata[0];
        count    = rdata[23:8];
    endtask

    task automatic check_frame(input int length);
        logic [31:0] expected;
        logic        last_bit;
        for (int d = 0; d < N_DEST; d++) begin
            for (int i = 0; i < length; i++) begin
                last_bit = d == N_DEST - 1 && i == length - 1;
                expected = {8'(DEST_START + d), 7'd0, last_bit,
                            16'(OUTPUT_BIAS + i + scope_pkg::CHANNEL_STEP * d)};
                read_expect(12'(int'(scope_pkg::BUF_BASE) + 4 * (d * length + i)), expected, 1'b0);
            end
        end
    endtask

    task automatic run_frame(input int length);
        logic        busy_bit;
        logic [15:0] base;
        logic [15:0] count;
        apb_write(scope_pkg::ADDR_LENGTH, 32'(length), 1'b0);
        cur_length = length;
        read_expect(scope_pkg::ADDR_LENGTH, 32'(length), 1'b0);
        read_status(busy_bit, base);
        apb_write(scope_pkg::ADDR_CTRL, 32'h2, 1'b0);
        // Trigger is a pulse and enable stays clear, so CTRL reads 0
        read_expect(scope_pkg::ADDR_CTRL, 32'd0, 1'b0);
        @(negedge clock);
        check_value("busy output during the frame", 32'(busy), 32'd1);
        count    = base;
        busy_bit = 1'b1;
        while (busy_bit || count == base) begin
            read_status(busy_bit, count);
        end
        check_value("frame_count after one frame", 32'(count), 32'(base) + 32'd1);
        check_outputs(1'b0, base + 16'd1);
        check_frame(length);
    endtask

    task automatic run_continuous(input int frames);
        logic        busy_bit;
        logic [15:0] base;
        logic [15:0] count;
        logic [15:0] settled;
        read_status(busy_bit, base);
        apb_write(scope_pkg::ADDR_CTRL, 32'h1, 1'b0);
        read_expect(scope_pkg::ADDR_CTRL, 32'h1, 1'b0);
        count = base;
        while (int'(16'(count - base)) < frames) begin
            read_status(busy_bit, count);
        end
        apb_write(scope_pkg::ADDR_CTRL, 32'h0, 1'b0);
        busy_bit = 1'b1;
        while (busy_bit) begin
            read_status(busy_bit, settled);
        end
        // A restarted sequencer would have finished another frame by now
        repeat (FRAME_CYCLES) @(posedge clock);
        read_status(busy_bit, count);
        check_value("busy with enable cleared", 32'(busy_bit), 32'd0);
        check_value("frame_count once stopped", 32'(count), 32'(settled));
        check_outputs(1'b0, settled);
        check_frame(cur_length);
    endtask

    task automatic finish_test();
        tests++;
        $display("test %0d %s with %0d errors", tests, test_errors == 0 ? "passed" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic load_testdata(output bit ok);
        int          fd;
        int          frames;
        string       line;
        logic [7:0]  c;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        frames = 0;
        fd     = $fopen("test/scope_testdata.txt", "r");
        ok     = fd != 0;
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                c = "#";
                a = 32'd0;
                d = 32'd0;
                e = 32'd0;
                void'($sscanf(line, "%c %h %h %h", c, a, d, e));
                // Frame lengths and frame counts are decimal
                if (c == "F" || c == "C") begin
                    void'($sscanf(line, "%c %d", c, a));
                end
                if (c != "#" && c != "\n") begin
                    cmd_q.push_back(c);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    err_q.push_back(e);
                    // Continuous runs may finish one frame more and need time to settle
                    frames += (c == "F") ? 1 : (c == "C") ? int'(a) + 2 : 0;
                end
            end
            $fclose(fd);
            watchdog_cycles = 2000 + 40 * cmd_q.size() + frames * (FRAME_CYCLES + 10 * BUFFER_DEPTH);
        end
    endtask

    initial begin
        bit ok;
        clock   = 1'b0;
        reset   = 1'b0;
        apb_req = '0;
        lfsr    = 32'h3780_9978;
        load_testdata(ok);
        repeat (10) @(posedge clock);
        reset <= 1'b1;
        if (!ok) begin
            errors++;
            $display("could not open test/scope_testdata.txt");
        end else begin
            check_outputs(1'b0, 16'd0);
            for (int k = 0; k < cmd_q.size(); k++) begin
                case (cmd_q[k])
                    "W": begin
                        apb_write(12'(addr_q[k]), data_q[k], err_q[k][0]);
                        if (12'(addr_q[k]) == scope_pkg::ADDR_LENGTH && !err_q[k][0]) begin
                            cur_length = int'(data_q[k]);
                        end
                    end
                    "R": read_expect(12'(addr_q[k]), data_q[k], err_q[k][0]);
                    "F": run_frame(int'(addr_q[k]));
                    "C": run_continuous(int'(addr_q[k]));
                    "E": finish_test();
                    default: begin
                        errors++;
                        $display("unknown command %c in the test data", cmd_q[k]);
                    end
                endcase
            end
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* test/scope_chk.sv */
// Bound APB and stream assertions; each bind ties off the ports that its target module lacks
`timescale 1ns/1ns

module scope_chk (
    input logic                    clock,
    input logic                    reset,
    input scope_pkg::apb_req_t     apb_req,
    input scope_pkg::apb_rsp_t     apb_rsp,
    input logic [15:0]             packet_length,
    input logic                    frame_done,
    input scope_pkg::sample_beat_t beat,
    input scope_pkg::seq_state_e   state
);

    // The access phase follows a setup cycle of the same transfer
    a_setup_first: assert property (@(posedge clock) disable iff (!reset)
        $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel))
        else $error("penable rose without a setup cycle");

    // A rejected transfer completes and leaves the packet length as it was
    a_err_ready: assert property (@(posedge clock) disable iff (!reset)
        apb_rsp.pslverr |-> apb_rsp.pready ##1 $stable(packet_length))
        else $error("pslverr without pready or a rejected write changed the length");

    // The sink answers a last beat with frame_done on the next cycle
    a_last_valid: assert property (@(posedge clock) disable iff (!reset)
        beat.last |-> beat.valid ##1 frame_done)
        else $error("last marker on an invalid beat or not followed by frame_done");

    // Once the frame is out the stream stays quiet and frame_done arrives at once
    a_quiet_wait: assert property (@(posedge clock) disable iff (!reset)
        state == scope_pkg::seq_wait_done |-> !beat.valid && frame_done)
        else $error("valid beat or missing frame_done while waiting for the sink");

endmodule

bind scope_regs scope_chk i_regs_chk (
    .clock, .reset, .apb_req, .apb_rsp, .packet_length,
    .frame_done (1'b0),
    .beat ('0),
    .state (scope_pkg::seq_idle)
);

bind sample_sequencer scope_chk i_seq_chk (
    .clock, .reset, .packet_length, .frame_done, .beat, .state,
    .apb_req ('0),
    .apb_rsp ('0)
);

/* design/scope_top.sv */
// Scope pattern source top level; the sample stream has no back-pressure and APB is the only control path
`timescale 1ns/1ns

module scope_top #(
    parameter int BACKOFF_DELAY = 128,
    parameter int OUTPUT_BIAS   = 0,
    parameter int DEST_START    = 1,
    parameter int N_DEST        = 4,
    parameter int BUFFER_DEPTH  = 64
) (
    input  logic                clock,
    input  logic                reset,
    input  scope_pkg::apb_req_t apb_req,
    output scope_pkg::apb_rsp_t apb_rsp,
    output logic                busy,
    output logic [15:0]         frame_count
);

    logic                            start;
    logic                            enable;
    logic [15:0]                     packet_length;
    logic                            frame_done;
    logic                            rd_en;
    logic [$clog2(BUFFER_DEPTH)-1:0] rd_addr;
    logic [31:0]                     rd_data;
    scope_pkg::sample_beat_t         beat;

    scope_regs #(
        .N_DEST       (N_DEST),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_regs (
        .clock         (clock),
        .reset         (reset),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .start         (start),
        .enable        (enable),
        .packet_length (packet_length),
        .busy          (busy),
        .frame_count   (frame_count),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    sample_sequencer #(
        .BACKOFF_DELAY (BACKOFF_DELAY),
        .OUTPUT_BIAS   (OUTPUT_BIAS),
        .DEST_START    (DEST_START),
        .N_DEST        (N_DEST)
    ) i_sequencer (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .enable        (enable),
        .packet_length (packet_length),
        .frame_done    (frame_done),
        .beat          (beat),
        .busy          (busy)
    );

    capture_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_buffer (
        .clock       (clock),
        .reset       (reset),
        .beat        (beat),
        .frame_done  (frame_done),
        .frame_count (frame_count),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

/* design/capture_buffer.sv */
// Capture memory standing in for the DMA target; a frame longer than BUFFER_DEPTH wraps and overwrites its own start
`timescale 1ns/1ns

module capture_buffer #(
    parameter int BUFFER_DEPTH = 64
) (
    input  logic                            clock,
    input  logic                            reset,
    input  scope_pkg::sample_beat_t         beat,
    output logic                            frame_done,
    output logic [15:0]                     frame_count,
    input  logic                            rd_en,
    input  logic [$clog2(BUFFER_DEPTH)-1:0] rd_addr,
    output logic [31:0]                     rd_data
);

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(BUFFER_DEPTH - 1);

    // Entries are kept in the layout of the APB window
    logic [31:0]       mem [BUFFER_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;

    always_ff @(posedge clock) begin
        if (beat.valid) begin
            mem[wr_ptr] <= {beat.dest, 7'd0, beat.last, beat.data};
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr      <= '0;
            frame_done  <= 1'b0;
            frame_count <= 16'd0;
        end else begin
            frame_done <= 1'b0;
            if (beat.valid) begin
                if (beat.last) begin
                    // Frame complete, so the next one lands at entry 0
                    wr_ptr      <= '0;
                    frame_done  <= 1'b1;
                    frame_count <= frame_count + 16'd1;
                end else if (wr_ptr == LAST_ADDR) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

endmodule

/* design/sample_sequencer.sv */
// Synthetic frame generator; packet_length must be at least 1, N_DEST fits 8-bit dest, BACKOFF_DELAY is 1 to 65536
`timescale 1ns/1ns

module sample_sequencer #(
    parameter int BACKOFF_DELAY = 128,
    parameter int OUTPUT_BIAS   = 0,
    parameter int DEST_START    = 1,
    parameter int N_DEST        = 4
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    enable,
    input  logic [15:0]             packet_length,
    input  logic                    frame_done,
    output scope_pkg::sample_beat_t beat,
    output logic                    busy
);

    localparam logic [7:0]  FIRST_DEST = 8'(DEST_START);
    localparam logic [7:0]  FINAL_DEST = 8'(DEST_START + N_DEST - 1);
    localparam logic [15:0] GAP_LOAD   = 16'(scope_pkg::SAMPLE_GAP - 1);
    localparam logic [15:0] BACKOFF_LOAD = 16'(BACKOFF_DELAY - 1);

    scope_pkg::seq_state_e state;

    logic [15:0] frame_length;
    logic [15:0] sample_index;
    logic [7:0]  dest_count;
    logic [15:0] delay_count;
    logic        last_index;
    logic        last_dest;
    logic        emit;

    // The length is taken while idle and then held for the whole frame
    always_ff @(posedge clock) begin
        if (state == scope_pkg::seq_idle) begin
            frame_length <= packet_length;
        end
    end

    assign last_index = sample_index == frame_length - 16'd1;
    assign last_dest  = dest_count == FINAL_DEST;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state        <= scope_pkg::seq_idle;
            sample_index <= 16'd0;
            dest_count   <= FIRST_DEST;
            delay_count  <= 16'd0;
        end else begin
            case (state)
                scope_pkg::seq_idle: begin
                    if (start || enable) begin
                        sample_index <= 16'd0;
                        dest_count   <= FIRST_DEST;
                        // One lead-in cycle in the gap state puts the first beat 2 cycles out
                        delay_count  <= 16'd0;
                        state        <= scope_pkg::seq_gap;
                    end
                end
                scope_pkg::seq_sample: begin
                    if (!last_index) begin
                        sample_index <= sample_index + 16'd1;
                        delay_count  <= GAP_LOAD;
                        state        <= scope_pkg::seq_gap;
                    end else if (!last_dest) begin
                        // Next channel starts right away, no gap
                        sample_index <= 16'd0;
                        dest_count   <= dest_count + 8'd1;
                    end else begin
                        sample_index <= 16'd0;
                        dest_count   <= FIRST_DEST;
                        state        <= scope_pkg::seq_wait_done;
                    end
                end
                scope_pkg::seq_gap: begin
                    if (delay_count == 16'd0) begin
                        state <= scope_pkg::seq_sample;
                    end else begin
                        delay_count <= delay_count - 16'd1;
                    end
                end
                scope_pkg::seq_wait_done: begin
                    if (frame_done) begin
                        delay_count <= BACKOFF_LOAD;
                        state       <= scope_pkg::seq_backoff;
                    end
                end
                scope_pkg::seq_backoff: begin
                    if (delay_count == 16'd0) begin
                        state <= scope_pkg::seq_idle;
                    end else begin
                        delay_count <= delay_count - 16'd1;
                    end
                end
                default: begin
                    state <= scope_pkg::seq_idle;
                end
            endcase
        end
    end

    // A beat goes out in every cycle spent in seq_sample
    assign emit = state == scope_pkg::seq_sample;

    always_comb begin
        beat.valid = emit;
        beat.last  = emit && last_index && last_dest;
        beat.dest  = dest_count;
        beat.data  = 16'(OUTPUT_BIAS + int'(sample_index) +
                         scope_pkg::CHANNEL_STEP * (int'(dest_count) - DEST_START));
    end

    assign busy = state != scope_pkg::seq_idle;

endmodule

/* design/scope_regs.sv */
// APB control block; register accesses have no wait state, buffer reads exactly one, and BUFFER_DEPTH must be 2 to 960
`timescale 1ns/1ns

module scope_regs #(
    parameter int N_DEST       = 4,
    parameter int BUFFER_DEPTH = 64
) (
    input  logic                            clock,
    input  logic                            reset,
    input  scope_pkg::apb_req_t             apb_req,
    output scope_pkg::apb_rsp_t             apb_rsp,
    output logic                            start,
    output logic                            enable,
    output logic [15:0]                     packet_length,
    input  logic                            busy,
    input  logic [15:0]                     frame_count,
    output logic                            rd_en,
    output logic [$clog2(BUFFER_DEPTH)-1:0] rd_addr,
    input  logic [31:0]                     rd_data
);

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);
    localparam int BUF_END = int'(scope_pkg::BUF_BASE) + 4 * BUFFER_DEPTH;
    // A whole frame of N_DEST packets has to fit in the capture buffer
    localparam logic [31:0] MAX_LENGTH = 32'(BUFFER_DEPTH / N_DEST);

    logic        access;
    logic        is_ctrl;
    logic        is_length;
    logic        is_status;
    logic        is_buf;
    logic        buf_read;
    logic        bad_length;
    logic        error;
    logic        pready;
    logic        wr_ok;
    logic        buf_pending;
    logic [11:0] buf_offset;

    assign access    = apb_req.psel && apb_req.penable;
    assign is_ctrl   = apb_req.paddr == scope_pkg::ADDR_CTRL;
    assign is_length = apb_req.paddr == scope_pkg::ADDR_LENGTH;
    assign is_status = apb_req.paddr == scope_pkg::ADDR_STATUS;

    // Word aligned addresses inside the window only
    assign is_buf = int'(apb_req.paddr) >= int'(scope_pkg::BUF_BASE) &&
                    int'(apb_req.paddr) < BUF_END &&
                    apb_req.paddr[1:0] == 2'b00;

    assign buf_offset = apb_req.paddr - scope_pkg::BUF_BASE;
    assign rd_addr    = buf_offset[ADDR_W+1:2];
    assign buf_read   = is_buf && !apb_req.pwrite;
    assign bad_length = apb_req.pwdata == 32'd0 || apb_req.pwdata > MAX_LENGTH;

    always_comb begin
        error = !(is_ctrl || is_length || is_status || is_buf);
        // STATUS and the buffer window are read only
        if (apb_req.pwrite && (is_status || is_buf)) begin
            error = 1'b1;
        end
        if (apb_req.pwrite && is_length && bad_length) begin
            error = 1'b1;
        end
    end

    // The memory read is registered, so a buffer read waits one cycle for rd_data
    assign rd_en  = access && buf_read && !buf_pending;
    assign pready = access && (!buf_read || buf_pending);
    assign wr_ok  = pready && apb_req.pwrite && !error;

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable        <= 1'b0;
            start         <= 1'b0;
            packet_length <= 16'd1;
            buf_pending   <= 1'b0;
        end else begin
            start       <= 1'b0;
            buf_pending <= rd_en;
            if (wr_ok && is_ctrl) begin
                enable <= apb_req.pwdata[scope_pkg::CTRL_ENABLE_BIT];
                // Trigger is not stored, it only fires the start pulse
                start  <= apb_req.pwdata[scope_pkg::CTRL_TRIGGER_BIT];
            end
            if (wr_ok && is_length) begin
                packet_length <= apb_req.pwdata[15:0];
            end
        end
    end

    always_comb begin
        apb_rsp.pready  = pready;
        apb_rsp.pslverr = pready && error;
        apb_rsp.prdata  = 32'd0;
        if (access && !apb_req.pwrite) begin
            if (is_ctrl) begin
                apb_rsp.prdata = {31'd0, enable};
            end else if (is_length) begin
                apb_rsp.prdata = {16'd0, packet_length};
            end else if (is_status) begin
                apb_rsp.prdata = {8'd0, frame_count, 7'd0, busy};
            end else if (is_buf) begin
                apb_rsp.prdata = rd_data;
            end
        end
    end

endmodule

/* design/scope_pkg.sv */
// Shared types and register map for the scope pattern source; the 12-bit APB address limits the buffer window to 960 entries
package scope_pkg;

    // APB requester side, driven by the bus master into the register block
    typedef struct packed {
        logic [11:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB completer side; pslverr only means something while pready is high
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // One beat of the sample stream; there is no ready, the sink always accepts
    typedef struct packed {
        logic        valid;
        logic        last;
        logic [7:0]  dest;
        logic [15:0] data;
    } sample_beat_t;

    // Sequencer states
    typedef enum logic [2:0] {
        seq_idle,
        seq_sample,
        seq_gap,
        seq_wait_done,
        seq_backoff
    } seq_state_e;

    // Register map, byte addresses
    localparam logic [11:0] ADDR_CTRL   = 12'h000;
    localparam logic [11:0] ADDR_LENGTH = 12'h004;
    localparam logic [11:0] ADDR_STATUS = 12'h008;

    // Buffer window, one 32-bit word per captured beat
    localparam logic [11:0] BUF_BASE    = 12'h100;

    // CTRL bit positions
    localparam int CTRL_ENABLE_BIT  = 0;
    localparam int CTRL_TRIGGER_BIT = 1;

    // Idle cycles between two samples of the same channel
    localparam int SAMPLE_GAP   = 6;

    // Data offset added per destination above DEST_START
    localparam int CHANNEL_STEP = 2000;

endpackage
